/* design/exu_alu.sv */
`timescale 1ns/1ps

module exu_alu import exu_pkg::*; (
    exu_issue_if.alu iss,
    output xlen_t    alu_value
);

    xlen_t               opa;
    xlen_t               opb;
    alu_fn_e             fn;
    logic [shamt_w-1:0]  shamt;
    logic                lt_s;
    logic                lt_u;
    logic                eq;

    // Operand and function selection.
    always_comb begin
        opa = iss.a_is_pc  ? iss.pc  : iss.src1;
        opb = iss.b_is_imm ? iss.imm : iss.src2;
        fn  = iss.op.alu;
        if (iss.kind == KIND_BRANCH) begin
            // Branches always compare registers.
            opa = iss.src1;
            opb = iss.src2;
        end
        if (iss.kind == KIND_JAL) begin
            fn = ADD;  // Jump target sum.
        end
    end

    assign shamt = opb[shamt_w-1:0];
    assign lt_s  = $signed(opa) < $signed(opb);
    assign lt_u  = opa < opb;
    assign eq    = opa == opb;

    always_comb begin
        alu_value = '0;
        case (fn)
            ADD:  alu_value = opa + opb;
            SUB:  alu_value = opa - opb;
            AND:  alu_value = opa & opb;
            OR:   alu_value = opa | opb;
            XOR:  alu_value = opa ^ opb;
            SLL:  alu_value = opa << shamt;
            SRL:  alu_value = opa >> shamt;
            SRA:  alu_value = xlen_t'($signed(opa) >>> shamt);
            SLT:  alu_value[0] = lt_s;
            SLTU: alu_value[0] = lt_u;
            EQ:   alu_value[0] = eq;
            NE:   alu_value[0] = ~eq;
            LT:   alu_value[0] = lt_s;
            GE:   alu_value[0] = ~lt_s;
            LTU:  alu_value[0] = lt_u;
            GEU:  alu_value[0] = ~lt_u;
            default: alu_value = '0;
        endcase
    end

endmodule

/* design/exu_commit.sv */
`timescale 1ns/1ps

module exu_commit import exu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  exu_kind_e kind,
    input  exu_op_u   op,
    input  xlen_t     csr_rdata,
    input  xlen_t     store_data,
    input  xlen_t     alu_value,
    input  xlen_t     br_target,
    input  xlen_t     link_addr,
    input  xlen_t     csr_wdata,
    input  logic      in_valid,
    output logic      in_ready,
    output logic      out_valid,
    input  logic      out_ready,
    output xlen_t     result,
    output xlen_t     csr_out,
    output xlen_t     store_out,
    output xlen_t     redirect_pc,
    output logic      redirect_valid
);

    xlen_t result_d;
    xlen_t redirect_pc_d;
    logic  redirect_d;
    logic  load;

    // Accept when empty or drained this cycle.
    assign in_ready = out_ready | ~out_valid;
    assign load     = in_valid & in_ready;

    always_comb begin
        result_d      = '0;
        redirect_d    = 1'b0;
        redirect_pc_d = '0;
        case (kind)
            KIND_ALU: result_d = alu_value;
            KIND_JAL: begin
                result_d      = link_addr;
                redirect_d    = 1'b1;
                redirect_pc_d = {alu_value[xlen-1:1], 1'b0};
            end
            KIND_BRANCH: begin
                if (alu_value[0]) begin  // Compare held.
                    redirect_d    = 1'b1;
                    redirect_pc_d = br_target;
                end
            end
            KIND_CSR: result_d = csr_rdata;  // Old value to rd.
            KIND_SYS: begin
                if (op.sys.sys_fn == SYS_ECALL || op.sys.sys_fn == SYS_MRET) begin
                    redirect_d    = 1'b1;
                    redirect_pc_d = csr_rdata;  // mtvec or mepc.
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid      <= 1'b0;
            redirect_valid <= 1'b0;
            result         <= '0;
            csr_out        <= '0;
            store_out      <= '0;
            redirect_pc    <= '0;
        end else if (load) begin
            out_valid      <= 1'b1;
            redirect_valid <= redirect_d;
            result         <= result_d;
            csr_out        <= csr_wdata;
            store_out      <= store_data;
            redirect_pc    <= redirect_pc_d;
        end else if (out_ready) begin
            out_valid      <= 1'b0;
            redirect_valid <= 1'b0;  // Never flag a redirect without an item.
        end
    end

endmodule

/* design/exu_issue_if.sv */
`timescale 1ns/1ps

interface exu_issue_if import exu_pkg::*; ();

    exu_kind_e kind;
    exu_op_u   op;
    xlen_t     pc;
    xlen_t     src1;
    xlen_t     src2;
    xlen_t     imm;
    logic      a_is_pc;   // Operand a is pc, else src1.
    logic      b_is_imm;  // Operand b is imm, else src2.
    xlen_t     csr_rdata; // Current CSR value.

    modport alu (
        input kind,
        input op,
        input pc,
        input src1,
        input src2,
        input imm,
        input a_is_pc,
        input b_is_imm
    );

    modport redir (
        input kind,
        input op,
        input pc,
        input src1,
        input imm,
        input csr_rdata
    );

endinterface

/* design/exu_pkg.sv */
package exu_pkg;

    localparam int xlen        = 32;
    localparam int link_offset = 4;  // Bytes from pc to return address.
    localparam int shamt_w     = 5;  // Shift amount bits of operand b.

    typedef logic [xlen-1:0] xlen_t;

    // Instruction class, chosen by decode.
    typedef enum logic [2:0] {
        KIND_ALU    = 3'd0,
        KIND_JAL    = 3'd1,  // Also covers jalr.
        KIND_BRANCH = 3'd2,
        KIND_CSR    = 3'd3,
        KIND_SYS    = 3'd4
    } exu_kind_e;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLL  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        SLT  = 4'd8,
        SLTU = 4'd9,
        // Branch compares, result is 1 or 0.
        EQ   = 4'd10,
        NE   = 4'd11,
        LT   = 4'd12,
        GE   = 4'd13,
        LTU  = 4'd14,
        GEU  = 4'd15
    } alu_fn_e;

    typedef enum logic [1:0] {
        CSR_NONE = 2'd0,
        CSR_RW   = 2'd1,
        CSR_RS   = 2'd2
    } csr_fn_e;

    typedef enum logic [1:0] {
        SYS_NONE  = 2'd0,
        SYS_ECALL = 2'd1,
        SYS_MRET  = 2'd2
    } sys_fn_e;

    typedef struct packed {
        csr_fn_e csr_fn;  // Upper two bits.
        sys_fn_e sys_fn;
    } sys_op_t;

    // Same 4-bit field. Use alu for ALU, JAL and BRANCH; sys for CSR and SYS.
    typedef union packed {
        alu_fn_e alu;
        sys_op_t sys;
    } exu_op_u;

endpackage

/* design/exu_redirect.sv */
`timescale 1ns/1ps

module exu_redirect import exu_pkg::*; (
    exu_issue_if.redir iss,
    output xlen_t      br_target,
    output xlen_t      link_addr,
    output xlen_t      csr_wdata
);

    sys_op_t sys;
    logic    is_csr;

    assign sys    = iss.op.sys;
    assign is_csr = iss.kind == KIND_CSR;

    // Taken-branch target and return address.
    assign br_target = iss.pc + iss.imm;
    assign link_addr = iss.pc + xlen_t'(link_offset);

    // New CSR value, only for CSR instructions.
    always_comb begin
        csr_wdata = '0;
        if (is_csr) begin
            case (sys.csr_fn)
                CSR_RW:  csr_wdata = iss.src1;
                CSR_RS:  csr_wdata = iss.src1 | iss.csr_rdata;
                default: csr_wdata = '0;
            endcase
        end
    end

endmodule

/* design/exu_top.sv */
`timescale 1ns/1ps

module exu_top import exu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    output logic      in_ready,
    input  exu_kind_e in_kind,
    input  exu_op_u   in_op,
    input  xlen_t     in_pc,
    input  xlen_t     in_src1,
    input  xlen_t     in_src2,
    input  xlen_t     in_imm,
    input  logic      in_a_is_pc,
    input  logic      in_b_is_imm,
    input  xlen_t     in_csr_rdata,
    output logic      out_valid,
    input  logic      out_ready,
    output xlen_t     out_result,
    output xlen_t     out_csr_wdata,
    output xlen_t     out_store_data,
    output logic      out_redirect_valid,
    output xlen_t     out_redirect_pc
);

    xlen_t alu_value;
    xlen_t br_target;
    xlen_t link_addr;
    xlen_t csr_wdata;

    exu_issue_if iss ();

    assign iss.kind      = in_kind;
    assign iss.op        = in_op;
    assign iss.pc        = in_pc;
    assign iss.src1      = in_src1;
    assign iss.src2      = in_src2;
    assign iss.imm       = in_imm;
    assign iss.a_is_pc   = in_a_is_pc;
    assign iss.b_is_imm  = in_b_is_imm;
    assign iss.csr_rdata = in_csr_rdata;

    exu_alu u_alu (
        .iss       (iss.alu),
        .alu_value (alu_value)
    );

    exu_redirect u_redirect (
        .iss       (iss.redir),
        .br_target (br_target),
        .link_addr (link_addr),
        .csr_wdata (csr_wdata)
    );

    // src2 doubles as store data.
    exu_commit u_commit (
        .clk            (clk),
        .rst            (rst),
        .kind           (in_kind),
        .op             (in_op),
        .csr_rdata      (in_csr_rdata),
        .store_data     (in_src2),
        .alu_value      (alu_value),
        .br_target      (br_target),
        .link_addr      (link_addr),
        .csr_wdata      (csr_wdata),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .result         (out_result),
        .csr_out        (out_csr_wdata),
        .store_out      (out_store_data),
        .redirect_pc    (out_redirect_pc),
        .redirect_valid (out_redirect_valid)
    );

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module exu_tb -o exu_sim

status=0
./obj_dir/exu_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log || [ "$status" -ne 0 ]; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

/* sources.f */
design/exu_pkg.sv
design/exu_issue_if.sv
design/exu_alu.sv
design/exu_redirect.sv
design/exu_commit.sv
design/exu_top.sv
verification/exu_asserts.sv
verification/exu_tb.sv

/* verification/exu_asserts.sv */
`timescale 1ns/1ps

module exu_asserts import exu_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  in_ready,
    input logic  out_valid,
    input logic  out_ready,
    input xlen_t out_result,
    input xlen_t out_csr_wdata,
    input xlen_t out_store_data,
    input logic  out_redirect_valid,
    input xlen_t out_redirect_pc
);

    // Held item may not move while the memory stage stalls.
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_result)
            && $stable(out_csr_wdata) && $stable(out_store_data)
            && $stable(out_redirect_valid) && $stable(out_redirect_pc))
        else $error("Output item changed while stalled.");

    redirect_valid: assert property (@(posedge clk) disable iff (rst)
        out_redirect_valid |-> out_valid)
        else $error("Redirect flagged without a valid item.");

    reset_idle: assert property (@(posedge clk)
        rst |-> !out_valid && !out_redirect_valid && in_ready)
        else $error("Outputs not idle during reset.");

endmodule

bind exu_top exu_asserts u_asserts (
    .clk                (clk),
    .rst                (rst),
    .in_ready           (in_ready),
    .out_valid          (out_valid),
    .out_ready          (out_ready),
    .out_result         (out_result),
    .out_csr_wdata      (out_csr_wdata),
    .out_store_data     (out_store_data),
    .out_redirect_valid (out_redirect_valid),
    .out_redirect_pc    (out_redirect_pc)
);

/* verification/exu_tb.sv */
`timescale 1ns/1ps

module exu_tb import exu_pkg::*; ();

    localparam int n_items     = 300;
    localparam int sweep_items = 64;  // Every ALU fn with every operand select.
    localparam int cycle_limit = n_items * 4 + 50;

    typedef struct packed {
        xlen_t result;
        xlen_t csr_wdata;
        xlen_t store_data;
        logic  redirect;
        xlen_t redirect_pc;
    } expect_t;

    logic      clk = 1'b0;
    logic      rst;
    logic      in_valid;
    logic      in_ready;
    exu_kind_e in_kind;
    exu_op_u   in_op;
    xlen_t     in_pc;
    xlen_t     in_src1;
    xlen_t     in_src2;
    xlen_t     in_imm;
    logic      in_a_is_pc;
    logic      in_b_is_imm;
    xlen_t     in_csr_rdata;
    logic      out_valid;
    logic      out_ready;
    xlen_t     out_result;
    xlen_t     out_csr_wdata;
    xlen_t     out_store_data;
    logic      out_redirect_valid;
    xlen_t     out_redirect_pc;

    logic [31:0] lfsr = 32'd71;
    expect_t     expq[$];
    expect_t     front;
    int          errors  = 0;
    int          checked = 0;
    int          cycles;
    int          sent;
    logic        accepted;

    exu_top u_exu_top (
        .clk                (clk),
        .rst                (rst),
        .in_valid           (in_valid),
        .in_ready           (in_ready),
        .in_kind            (in_kind),
        .in_op              (in_op),
        .in_pc              (in_pc),
        .in_src1            (in_src1),
        .in_src2            (in_src2),
        .in_imm             (in_imm),
        .in_a_is_pc         (in_a_is_pc),
        .in_b_is_imm        (in_b_is_imm),
        .in_csr_rdata       (in_csr_rdata),
        .out_valid          (out_valid),
        .out_ready          (out_ready),
        .out_result         (out_result),
        .out_csr_wdata      (out_csr_wdata),
        .out_store_data     (out_store_data),
        .out_redirect_valid (out_redirect_valid),
        .out_redirect_pc    (out_redirect_pc)
    );

    always #20 clk = ~clk;

    // Galois LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end else begin
            return s >> 1;
        end
    endfunction

    function automatic xlen_t rand_bits(input int n);
        xlen_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[xlen-2:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic xlen_t alu_ref(input alu_fn_e fn, input xlen_t a, input xlen_t b);
        logic [4:0] sh;
        logic       lt_s;
        sh   = b[4:0];
        lt_s = (a[31] != b[31]) ? a[31] : (a < b);  // Negative one is less when signs differ.
        case (fn)
            ADD:       return a + b;
            SUB:       return a + ~b + 32'd1;
            AND:       return a & b;
            OR:        return a | b;
            XOR:       return a ^ b;
            SLL:       return a << sh;
            SRL:       return a >> sh;
            SRA:       return (a >> sh) | (a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'd0);
            SLT, LT:   return xlen_t'(lt_s);
            SLTU, LTU: return xlen_t'(a < b);
            EQ:        return xlen_t'(a == b);
            NE:        return xlen_t'(a != b);
            GE:        return xlen_t'(!lt_s);
            GEU:       return xlen_t'(a >= b);
            default:   return '0;
        endcase
    endfunction

    function automatic expect_t ref_model(input exu_kind_e kind, input exu_op_u op,
                                          input xlen_t pc, input xlen_t src1,
                                          input xlen_t src2, input xlen_t imm,
                                          input logic a_is_pc, input logic b_is_imm,
                                          input xlen_t csr_rdata);
        expect_t e;
        xlen_t   a;
        xlen_t   b;
        xlen_t   v;
        e = '0;
        a = a_is_pc ? pc : src1;
        b = b_is_imm ? imm : src2;
        if (kind == KIND_BRANCH) begin
            a = src1;
            b = src2;
        end
        v = alu_ref((kind == KIND_JAL) ? ADD : op.alu, a, b);
        e.store_data = src2;
        case (kind)
            KIND_ALU: e.result = v;
            KIND_JAL: begin
                e.result      = pc + 32'd4;
                e.redirect    = 1'b1;
                e.redirect_pc = v & ~32'd1;
            end
            KIND_BRANCH: begin
                e.redirect    = v[0];
                e.redirect_pc = v[0] ? pc + imm : '0;
            end
            KIND_CSR: begin
                e.result = csr_rdata;
                if (op.sys.csr_fn == CSR_RW) e.csr_wdata = src1;
                if (op.sys.csr_fn == CSR_RS) e.csr_wdata = src1 | csr_rdata;
            end
            KIND_SYS: begin
                if (op.sys.sys_fn == SYS_ECALL || op.sys.sys_fn == SYS_MRET) begin
                    e.redirect    = 1'b1;
                    e.redirect_pc = csr_rdata;
                end
            end
            default: ;
        endcase
        return e;
    endfunction

    task automatic make_instr(input int idx);
        logic [2:0]  k;
        logic [3:0]  fn;
        logic [11:0] imm12;
        in_pc        = rand_bits(32) & 32'hFFFF_FFFC;
        in_src1      = rand_bits(32);
        in_src2      = (rand_bits(2) == 0) ? in_src1 : rand_bits(32);  // Some equal pairs.
        imm12        = 12'(rand_bits(12));
        in_imm       = {{20{imm12[11]}}, imm12};
        in_csr_rdata = rand_bits(32);
        in_a_is_pc   = rand_bits(1) != 0;
        in_b_is_imm  = rand_bits(1) != 0;
        in_op        = '0;
        if (idx < sweep_items) begin
            in_kind     = KIND_ALU;
            in_op.alu   = alu_fn_e'(idx[3:0]);
            in_a_is_pc  = idx[4];
            in_b_is_imm = idx[5];
        end else begin
            k       = 3'(rand_bits(3) % 5);
            in_kind = exu_kind_e'(k);
            fn      = 4'(rand_bits(4));
            if (in_kind == KIND_BRANCH) fn = 4'(10 + rand_bits(3) % 6);
            if (in_kind == KIND_CSR) begin
                in_op.sys.csr_fn = csr_fn_e'(2'(rand_bits(2) % 3));
            end else if (in_kind == KIND_SYS) begin
                in_op.sys.sys_fn = sys_fn_e'(2'(rand_bits(2) % 3));
            end else begin
                in_op.alu = alu_fn_e'(fn);
            end
        end
    endtask

    task automatic check_word(input string name, input xlen_t expected, input xlen_t actual);
        if (expected !== actual) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_redirect(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            errors++;
            $display("Fail %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // Scoreboard samples mid-cycle where outputs are settled.
    always @(negedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (expq.size() == 0) begin
                errors++;
                $display("An output item appeared that was never accepted at the input.");
            end else begin
                front = expq.pop_front();
                check_word($sformatf("item %0d result", checked), front.result, out_result);
                check_word($sformatf("item %0d csr", checked), front.csr_wdata, out_csr_wdata);
                check_word($sformatf("item %0d store", checked), front.store_data,
                           out_store_data);
                check_redirect($sformatf("item %0d redirect", checked), front.redirect,
                               out_redirect_valid);
                check_word($sformatf("item %0d redirect pc", checked), front.redirect_pc,
                           out_redirect_pc);
                checked++;
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("The run hung: %0d cycles passed and only %0d items came out.", cycles, checked);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_kind      = KIND_ALU;
        in_op        = '0;
        in_pc        = '0;
        in_src1      = '0;
        in_src2      = '0;
        in_imm       = '0;
        in_a_is_pc   = 1'b0;
        in_b_is_imm  = 1'b0;
        in_csr_rdata = '0;
        out_ready    = 1'b0;
        repeat (4) @(posedge clk);
        #2 rst = 1'b0;
        @(negedge clk);
        check_redirect("reset out_valid", 1'b0, out_valid);
        check_redirect("reset out_redirect_valid", 1'b0, out_redirect_valid);
        check_redirect("reset in_ready", 1'b1, in_ready);
        check_word("reset out_result", '0, out_result);
        check_word("reset out_csr_wdata", '0, out_csr_wdata);
        check_word("reset out_store_data", '0, out_store_data);
        check_word("reset out_redirect_pc", '0, out_redirect_pc);
        @(posedge clk);
        #2;
        sent = 0;
        make_instr(0);
        in_valid = 1'b1;
        while (sent < n_items) begin
            out_ready = rand_bits(2) != 0;  // Stall about a quarter of cycles.
            @(negedge clk);
            accepted = in_ready;
            if (accepted) begin
                expq.push_back(ref_model(in_kind, in_op, in_pc, in_src1, in_src2, in_imm,
                                         in_a_is_pc, in_b_is_imm, in_csr_rdata));
                sent++;
            end
            @(posedge clk);
            #2;
            if (accepted && sent < n_items) make_instr(sent);
            if (accepted && sent == n_items) in_valid = 1'b0;
        end
        out_ready = 1'b1;
        while (checked < n_items) @(posedge clk);
        @(negedge clk);
        check_redirect("drained out_valid", 1'b0, out_valid);
        if (expq.size() != 0) begin
            errors++;
            $display("%0d expected items were never seen at the output.", expq.size());
        end
        $display("Items checked %0d of %0d, errors %0d", checked, n_items, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
